//--- hw/lcd_pkg.sv
package lcd_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Panel timing for the 480x272 display.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [15:0] count_t;
	typedef logic [8:0] gray_t;

	localparam count_t h_active = 16'd480;
	localparam count_t h_front = 16'd8;
	localparam count_t h_sync = 16'd4;
	localparam count_t h_back = 16'd40;
	localparam count_t h_total = h_active + h_front + h_sync + h_back;

	localparam count_t v_active = 16'd272;
	localparam count_t v_front = 16'd4;
	localparam count_t v_sync = 16'd4;
	localparam count_t v_back = 16'd8;
	localparam count_t v_total = v_active + v_front + v_sync + v_back;

	localparam count_t hs_start = h_active + h_front;
	localparam count_t hs_stop = hs_start + h_sync;
	localparam count_t vs_start = v_active + v_front;
	localparam count_t vs_stop = vs_start + v_sync;

	// The picture window and the video RAM behind it.
	localparam int img_size = 64;
	localparam int win_scale = 4;
	localparam int win_size = img_size * win_scale;
	localparam count_t win_x = 16'd112;
	localparam count_t win_y = 16'd8;
	localparam int vram_depth = img_size * img_size;
	localparam int vram_addr_w = $clog2(vram_depth);

	typedef struct packed {
		logic we;
		logic [vram_addr_w-1:0] addr;
		gray_t wdata;
	} vram_req_t;

	// Syncs are active low.
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic den;
	} lcd_sync_t;

	localparam lcd_sync_t sync_idle = '{hsync: 1'b1, vsync: 1'b1, den: 1'b0};

	typedef struct packed {
		logic [4:0] b;
		logic [5:0] g;
		logic [4:0] r;
	} rgb565_t;

	// A diagonal ramp with a checkerboard of 8x8 blocks in the top bit.
	function automatic gray_t image_word(input logic [vram_addr_w-1:0] addr);
		logic [5:0] row;
		logic [5:0] col;
		logic [7:0] level;
		row = addr[11:6];
		col = addr[5:0];
		level = {2'b00, row} + {2'b00, col};
		level = level << 2;
		return {row[3] ^ col[3], level};
	endfunction

endpackage

//--- hw/lcd_timing.sv
`timescale 1ns/1ps

module lcd_timing (
	input logic pixel_clk,
	input logic rst,
	output lcd_pkg::count_t pixel_count,
	output lcd_pkg::count_t line_count,
	output lcd_pkg::lcd_sync_t sync
);
	import lcd_pkg::*;

	count_t pixel_next;
	count_t line_next;
	logic line_end;
	logic frame_end;
	lcd_sync_t sync_next;

	always_comb begin
		line_end = (pixel_count == h_total - 16'd1);
		frame_end = (line_count == v_total - 16'd1);

		if (line_end) begin
			pixel_next = '0;
		end else begin
			pixel_next = pixel_count + 16'd1;
		end

		if (!line_end) begin
			line_next = line_count;
		end else if (frame_end) begin
			line_next = '0;
		end else begin
			line_next = line_count + 16'd1;
		end
	end

	// The flags are decoded from the next counts so that, once registered,
	// they line up with the counter values they describe.
	always_comb begin
		sync_next.den = (pixel_next < h_active) && (line_next < v_active);
		sync_next.hsync = !((pixel_next >= hs_start) && (pixel_next < hs_stop));
		sync_next.vsync = !((line_next >= vs_start) && (line_next < vs_stop));
	end

	// Reset parks the counters on the last blanking pixel of the frame, so
	// the first count after release is the first active pixel.
	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			pixel_count <= h_total - 16'd1;
			line_count <= v_total - 16'd1;
			sync <= sync_idle;
		end else begin
			pixel_count <= pixel_next;
			line_count <= line_next;
			sync <= sync_next;
		end
	end

endmodule

//--- hw/frame_loader.sv
`timescale 1ns/1ps

module frame_loader (
	input logic pixel_clk,
	input logic rst,
	input logic wr_gnt,
	output lcd_pkg::vram_req_t wr_req
);
	import lcd_pkg::*;

	logic [vram_addr_w-1:0] addr;
	logic running;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Address walk. The request is held until the arbiter grants it.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			running <= 1'b0;
			addr <= '0;
		end else begin
			running <= 1'b1;
			// The address is exactly vram_addr_w bits wide, so it wraps at
			// vram_depth on its own and the loader keeps rewriting forever.
			if (running && wr_gnt) begin
				addr <= addr + 1'b1;
			end
		end
	end

	always_comb begin
		wr_req.we = running;
		wr_req.addr = addr;
		wr_req.wdata = image_word(addr);
	end

endmodule

//--- hw/vram_arbiter.sv
`timescale 1ns/1ps

module vram_arbiter (
	input logic rd_req,
	input logic [lcd_pkg::vram_addr_w-1:0] rd_addr,
	input lcd_pkg::vram_req_t wr_req,
	output logic wr_gnt,
	output lcd_pkg::vram_req_t ram_req
);
	import lcd_pkg::*;

	vram_req_t rd_port;

	// The display reader is a read-only client of the port.
	always_comb begin
		rd_port.we = 1'b0;
		rd_port.addr = rd_addr;
		rd_port.wdata = wr_req.wdata;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Fixed priority. A read that loses the port would tear the picture,
	// while a delayed write only slows the loader down.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		wr_gnt = !rd_req;
		if (rd_req) begin
			ram_req = rd_port;
		end else begin
			ram_req = wr_req;
		end
	end

endmodule

//--- hw/video_ram.sv
`timescale 1ns/1ps

module video_ram (
	input logic pixel_clk,
	input lcd_pkg::vram_req_t ram_req,
	output lcd_pkg::gray_t rd_data
);
	import lcd_pkg::*;

	gray_t mem [vram_depth];

	// Single port: the read word is registered every cycle, and a write
	// returns the old contents of the addressed word.
	always_ff @(posedge pixel_clk) begin
		if (ram_req.we) begin
			mem[ram_req.addr] <= ram_req.wdata;
		end
		rd_data <= mem[ram_req.addr];
	end

endmodule

//--- hw/pixel_mixer.sv
`timescale 1ns/1ps

module pixel_mixer (
	input logic pixel_clk,
	input logic rst,
	input lcd_pkg::count_t pixel_count,
	input lcd_pkg::count_t line_count,
	input lcd_pkg::lcd_sync_t sync_in,
	input lcd_pkg::gray_t rd_data,
	output logic rd_req,
	output logic [lcd_pkg::vram_addr_w-1:0] rd_addr,
	output lcd_pkg::lcd_sync_t sync,
	output lcd_pkg::rgb565_t color
);
	import lcd_pkg::*;

	count_t rel_x;
	count_t rel_y;
	count_t img_col;
	count_t img_row;
	logic in_x;
	logic in_y;
	logic in_win_d;
	rgb565_t grad_d;
	lcd_sync_t sync_d;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stage 0: window test and RAM address from the live counters.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		rel_x = pixel_count - win_x;
		rel_y = line_count - win_y;
		img_col = rel_x / count_t'(win_scale);
		img_row = rel_y / count_t'(win_scale);
		in_x = (pixel_count >= win_x) && (pixel_count < win_x + win_size);
		in_y = (line_count >= win_y) && (line_count < win_y + win_size);
		// The reader owns the port across the window columns on every line.
		rd_req = in_x;
		rd_addr = {img_row[5:0], img_col[5:0]};
	end

	// Stage 1: hold everything else while the RAM read is in flight.
	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			in_win_d <= 1'b0;
			grad_d <= '0;
			sync_d <= sync_idle;
			sync <= sync_idle;
			color <= '0;
		end else begin
			in_win_d <= in_x && in_y;
			grad_d <= rgb565_t'(line_count + pixel_count);
			sync_d <= sync_in;
			sync <= sync_d;
			if (in_win_d) begin
				color <= '{b: rd_data[8:4], g: rd_data[8:3], r: rd_data[8:4]};
			end else begin
				color <= grad_d;
			end
		end
	end

endmodule

//--- hw/lcd_top.sv
`timescale 1ns/1ps

module lcd_top (
	input logic pixel_clk,
	input logic rst,
	output logic lcd_clk,
	output logic lcd_hsync,
	output logic lcd_vsync,
	output logic lcd_den,
	output logic [4:0] lcd_r,
	output logic [5:0] lcd_g,
	output logic [4:0] lcd_b
);
	import lcd_pkg::*;

	count_t pixel_count;
	count_t line_count;
	lcd_sync_t timing_sync;
	lcd_sync_t panel_sync;
	rgb565_t color;
	logic rd_req;
	logic [vram_addr_w-1:0] rd_addr;
	logic wr_gnt;
	vram_req_t wr_req;
	vram_req_t ram_req;
	gray_t rd_data;

	lcd_timing timing (
		.pixel_clk(pixel_clk),
		.rst(rst),
		.pixel_count(pixel_count),
		.line_count(line_count),
		.sync(timing_sync)
	);

	pixel_mixer mixer (
		.pixel_clk(pixel_clk),
		.rst(rst),
		.pixel_count(pixel_count),
		.line_count(line_count),
		.sync_in(timing_sync),
		.rd_data(rd_data),
		.rd_req(rd_req),
		.rd_addr(rd_addr),
		.sync(panel_sync),
		.color(color)
	);

	frame_loader loader (
		.pixel_clk(pixel_clk),
		.rst(rst),
		.wr_gnt(wr_gnt),
		.wr_req(wr_req)
	);

	vram_arbiter arbiter (
		.rd_req(rd_req),
		.rd_addr(rd_addr),
		.wr_req(wr_req),
		.wr_gnt(wr_gnt),
		.ram_req(ram_req)
	);

	video_ram vmem (
		.pixel_clk(pixel_clk),
		.ram_req(ram_req),
		.rd_data(rd_data)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Panel pins.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign lcd_clk = pixel_clk;
	assign lcd_hsync = panel_sync.hsync;
	assign lcd_vsync = panel_sync.vsync;
	assign lcd_den = panel_sync.den;
	assign lcd_r = color.r;
	assign lcd_g = color.g;
	assign lcd_b = color.b;

endmodule

//--- tests/lcd_top_sva.sv
`timescale 1ns/1ps

module lcd_top_sva (
	input logic pixel_clk,
	input logic rst,
	input logic lcd_clk,
	input logic lcd_hsync,
	input logic lcd_vsync,
	input logic lcd_den
);
	import lcd_pkg::*;

	count_t hsync_low;

	// Length of the running hsync pulse, read back when the pulse ends.
	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			hsync_low <= '0;
		end else if (!lcd_hsync) begin
			hsync_low <= hsync_low + 16'd1;
		end else begin
			hsync_low <= '0;
		end
	end

	den_outside_sync: assert property (@(posedge pixel_clk) disable iff (!rst)
		lcd_den |-> (lcd_hsync && lcd_vsync))
		else $error("den is high while a sync pulse is active");

	hsync_width: assert property (@(posedge pixel_clk) disable iff (!rst)
		$rose(lcd_hsync) |-> (hsync_low == h_sync))
		else $error("hsync pulse lasted %0d cycles", hsync_low);

	lcd_clk_low: assert property (@(posedge pixel_clk) !lcd_clk)
		else $error("lcd_clk is not low before a rising pixel_clk edge");

	lcd_clk_high: assert property (@(negedge pixel_clk) lcd_clk)
		else $error("lcd_clk is not high before a falling pixel_clk edge");

endmodule

bind lcd_top lcd_top_sva sva (
	.pixel_clk(pixel_clk),
	.rst(rst),
	.lcd_clk(lcd_clk),
	.lcd_hsync(lcd_hsync),
	.lcd_vsync(lcd_vsync),
	.lcd_den(lcd_den)
);

//--- tests/lcd_top_tb.sv
`timescale 1ns/1ps

module lcd_top_tb;
	import lcd_pkg::*;

	localparam int frame_cycles = int'(h_total) * int'(v_total);

	logic pixel_clk = 1'b0;
	logic rst = 1'b0;
	logic lcd_clk;
	logic lcd_hsync;
	logic lcd_vsync;
	logic lcd_den;
	logic [4:0] lcd_r;
	logic [5:0] lcd_g;
	logic [4:0] lcd_b;

	logic [31:0] lfsr = 32'h3708_51c0;
	int trk_row = 0;
	int trk_col = 0;
	int run_cnt = 0;
	int trk_frame = 0;
	logic prev_den = 1'b0;
	logic prev_vsync = 1'b1;
	int errors = 0;
	int tests_run = 0;
	int failed_tests = 0;
	bit timed_out = 1'b0;
	string pin_name [3] = '{"lcd_den", "lcd_hsync", "lcd_vsync"};

	lcd_top uut (
		.pixel_clk(pixel_clk),
		.rst(rst),
		.lcd_clk(lcd_clk),
		.lcd_hsync(lcd_hsync),
		.lcd_vsync(lcd_vsync),
		.lcd_den(lcd_den),
		.lcd_r(lcd_r),
		.lcd_g(lcd_g),
		.lcd_b(lcd_b)
	);

	initial begin
		forever #10 pixel_clk = ~pixel_clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Screen position of the pixel on the panel pins, rebuilt from den and vsync.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always begin
		@(posedge pixel_clk);
		#2;
		if (rst) begin
			if (lcd_den) begin
				trk_col = run_cnt;
				run_cnt++;
			end
			if (prev_den && !lcd_den) begin
				run_cnt = 0;
				trk_row++;
			end
			if (prev_vsync && !lcd_vsync) begin
				trk_row = 0;
				trk_frame++;
			end
			prev_den = lcd_den;
			prev_vsync = lcd_vsync;
		end
	end

	function automatic int next_bits(input int n);
		logic fb;
		int value;
		value = 0;
		repeat (n) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			value = (value << 1) | int'(fb);
		end
		return value;
	endfunction

	// Gray window with 4x scaling, else the line plus pixel gradient.
	function automatic logic [15:0] expected_color(input int row, input int col);
		int ir;
		int ic;
		int word;
		logic [8:0] w;
		if (row >= int'(win_y) && row < int'(win_y) + win_size
				&& col >= int'(win_x) && col < int'(win_x) + win_size) begin
			ir = (row - int'(win_y)) / win_scale;
			ic = (col - int'(win_x)) / win_scale;
			word = ((ir + ic) * 4) % 256;
			if (((ir / 8) + (ic / 8)) % 2 == 1) begin
				word = word + 256;
			end
			w = word[8:0];
			return {w[8:4], w[8:3], w[8:4]};
		end
		word = row + col;
		return word[15:0];
	endfunction

	function automatic logic [15:0] panel_color();
		return {lcd_b, lcd_g, lcd_r};
	endfunction

	task automatic check_equal(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got == exp) else begin
			$display("[FAIL] %s: got %h, expected %h", what, got, exp);
			errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		timed_out = 1'b1;
		errors++;
	endtask

	task automatic wait_for_pin(input int which, input logic level, input int limit,
			output int cycles, output bit ok);
		logic now;
		ok = 1'b0;
		cycles = 0;
		while (!ok && cycles < limit) begin
			@(negedge pixel_clk);
			cycles++;
			now = (which == 0) ? lcd_den : (which == 1) ? lcd_hsync : lcd_vsync;
			ok = (now == level);
		end
		if (!ok) begin
			report_timeout($sformatf("%s to become %b", pin_name[which], level));
		end
	endtask

	task automatic visit_pixel(input int row, input int col, output bit ok);
		int n;
		ok = 1'b0;
		n = 0;
		while (!ok && n < 2 * frame_cycles) begin
			@(negedge pixel_clk);
			n++;
			ok = lcd_den && trk_row == row && trk_col == col;
		end
		if (!ok) begin
			report_timeout($sformatf("line %0d, column %0d to be shown", row, col));
		end
	endtask

	task automatic close_test(input string name, input int start);
		tests_run++;
		if (errors > start) begin
			failed_tests++;
			$display("%s: %0d errors", name, errors - start);
		end else begin
			$display("%s: ok", name);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Directed tests.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic check_reset();
		int start;
		start = errors;
		for (int i = 0; i < 5; i++) begin
			@(posedge pixel_clk);
			// Release comes after the fourth clock edge in reset.
			if (i == 3) begin
				#1 rst = 1'b1;
			end
			@(negedge pixel_clk);
			check_equal("lcd_den", lcd_den, 0);
			check_equal("lcd_hsync", lcd_hsync, 1);
			check_equal("lcd_vsync", lcd_vsync, 1);
			// The last sample follows the first clock after release.
			check_equal("color", panel_color(), 0);
		end
		close_test("reset state", start);
	endtask

	task automatic measure_line_timing();
		int start;
		int low;
		int high;
		bit ok;
		start = errors;
		wait_for_pin(1, 1'b0, 2 * int'(h_total), low, ok);
		if (ok) wait_for_pin(1, 1'b1, int'(h_total), low, ok);
		if (ok) wait_for_pin(1, 1'b0, int'(h_total), high, ok);
		if (ok) begin
			check_equal("hsync low cycles", low, h_sync);
			check_equal("hsync period", low + high, h_total);
		end
		if (ok) wait_for_pin(0, 1'b1, 2 * int'(h_total), low, ok);
		if (ok) wait_for_pin(0, 1'b0, int'(h_total), high, ok);
		if (ok) wait_for_pin(0, 1'b1, int'(h_total), low, ok);
		if (ok) begin
			check_equal("den high cycles", high, h_active);
			check_equal("den gap cycles", low, h_front + h_sync + h_back);
		end
		close_test("line timing", start);
	endtask

	task automatic sample_gradient();
		int start;
		int pick;
		int row;
		int col;
		int n;
		bit ok;
		start = errors;
		n = 0;
		while (trk_frame < 1 && n < 2 * frame_cycles) begin
			@(negedge pixel_clk);
			n++;
		end
		ok = (trk_frame >= 1);
		if (!ok) report_timeout("frame 1");
		// One sample per band of 34 lines keeps the samples in raster order.
		for (int i = 0; i < 8 && ok; i++) begin
			pick = next_bits(5);
			row = i * 34 + pick;
			pick = next_bits(9);
			col = pick % int'(h_active);
			if (row >= int'(win_y) && row < int'(win_y) + win_size) begin
				col = pick % (int'(h_active) - win_size);
				if (col >= int'(win_x)) col = col + win_size;
			end
			visit_pixel(row, col, ok);
			if (ok) begin
				check_equal($sformatf("color at line %0d, column %0d", row, col),
					panel_color(), expected_color(row, col));
			end
		end
		close_test("background gradient", start);
	endtask

	task automatic probe_window_edges();
		int rows [8] = '{7, 8, 8, 100, 100, 263, 263, 264};
		int cols [8] = '{200, 112, 367, 111, 368, 112, 367, 200};
		int start;
		bit ok;
		start = errors;
		ok = 1'b1;
		for (int i = 0; i < 8 && ok; i++) begin
			visit_pixel(rows[i], cols[i], ok);
			if (ok) begin
				check_equal($sformatf("color at line %0d, column %0d", rows[i], cols[i]),
					panel_color(), expected_color(rows[i], cols[i]));
			end
		end
		close_test("window edges", start);
	endtask

	task automatic verify_scaling();
		int start;
		int changes;
		logic [15:0] got;
		logic [15:0] last;
		bit ok;
		start = errors;
		changes = 0;
		last = '0;
		visit_pixel(40, int'(win_x), ok);
		for (int k = 0; k < 64 && ok; k++) begin
			if (k > 0) @(negedge pixel_clk);
			got = panel_color();
			check_equal($sformatf("color at window column %0d", k), got,
				expected_color(40, int'(win_x) + k));
			if (k > 0 && got != last) begin
				changes++;
				assert (k % win_scale == 0) else begin
					$display("color changed at window column %0d, off the 4 pixel grid", k);
					errors++;
				end
			end
			last = got;
		end
		if (ok) begin
			assert (changes > 0) else begin
				$display("color never changed across the 64 pixel run");
				errors++;
			end
		end
		close_test("4x scaling", start);
	endtask

	task automatic measure_frame_timing();
		int start;
		int low;
		int runs;
		int n;
		logic was_den;
		bit ok;
		start = errors;
		wait_for_pin(2, 1'b0, 2 * frame_cycles, low, ok);
		if (ok) wait_for_pin(2, 1'b1, frame_cycles, low, ok);
		if (ok) begin
			check_equal("vsync low cycles", low, int'(v_sync) * int'(h_total));
			runs = 0;
			n = 0;
			was_den = lcd_den;
			ok = 1'b0;
			while (!ok && n < frame_cycles + int'(h_total)) begin
				@(negedge pixel_clk);
				n++;
				if (lcd_den && !was_den) runs++;
				was_den = lcd_den;
				ok = !lcd_vsync;
			end
			if (ok) begin
				check_equal("den runs per frame", runs, v_active);
			end else begin
				report_timeout("the next vsync pulse");
			end
		end
		close_test("frame timing", start);
	endtask

	initial begin
		check_reset();
		if (!timed_out) measure_line_timing();
		if (!timed_out) sample_gradient();
		if (!timed_out) probe_window_edges();
		if (!timed_out) verify_scaling();
		if (!timed_out) measure_frame_timing();
		$display("tests %0d, failed %0d, errors %0d", tests_run, failed_tests, errors);
		if (failed_tests == 0 && !timed_out) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

//--- list.f
hw/lcd_pkg.sv
hw/lcd_timing.sv
hw/frame_loader.sv
hw/vram_arbiter.sv
hw/video_ram.sv
hw/pixel_mixer.sv
hw/lcd_top.sv
tests/lcd_top_sva.sv
tests/lcd_top_tb.sv

//--- Makefile
TOP = lcd_top_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -Wno-fatal --timing --assert --top-module $(TOP) -f list.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f list.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
